//--- bench/stim_input.txt
// wcnt0 wcnt1 rcnt0 rcnt1 loads max_stall wr_len rd_len chan dir(1=read) first_addr
// loads: bit0 wr_load[0], bit1 wr_load[1], bit2 rd_load
004 000 064 064 1 3 04 04 0 0 0000100  // ch0 write, page toggled to 0
008 008 002 002 1 4 06 04 0 0 1000100  // both want, ch0 wins, page back to 1
000 005 002 064 0 2 05 04 1 0 3000000  // ch1 write beats ch0 read
000 000 002 003 4 3 05 04 0 1 0000040  // read frame, ch0 read on page 0
000 006 064 064 2 2 04 04 1 0 2000100  // ch1 write page toggled to 0
000 000 064 001 0 3 08 03 1 1 2000040  // ch1 read continues from rewind
000 000 064 004 4 4 08 05 1 1 3000040  // read frame, ch1 page 1
003 000 064 064 1 5 03 04 0 0 0000100  // ch0 write rewinds again
000 000 000 064 0 3 08 06 0 1 0000040  // ch0 read after rewind

//--- compile.f
design/ddr_cfg_pkg.sv
design/ddr_ui_pkg.sv
design/frame_sync.sv
design/addr_gen.sv
design/burst_arbiter.sv
design/rd_data_router.sv
design/ddr_frame_top.sv
bench/clk_gen.sv
bench/tb_top.sv

//--- run_sim.sh
#!/bin/sh
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal --top-module tb_top -f compile.f -o tb_top > sim.log 2>&1 \
    && ./obj_dir/tb_top >> sim.log 2>&1 \
    || { echo "build or simulation failed, see sim.log"; exit 1; }
grep -q "Errors found" sim.log && { echo "FAIL"; exit 1; } || { echo "PASS"; exit 0; }

//--- bench/tb_top.sv
`timescale 1ns/100ps

module tb_top
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
();

    localparam int NSC       = 9;                                 // scenarios in the data file
    localparam int NF        = 11;                                // words per scenario
    localparam int RD_LAT    = 6;                                 // responder read latency
    localparam int LIMIT_CYC = NSC * 200 + 100;

    logic                            ui_clk;
    logic                            rst_n;
    logic                            init_calib_complete;
    logic                            app_rdy;
    logic                            app_wdf_rdy;
    logic                            app_rd_data_valid = 1'b0;
    logic [DATA_W-1:0]               app_rd_data = '0;
    fifo_level_t                     levels;
    logic [CHAN_NUM-1:0]             wr_load;
    logic                            rd_load;
    logic [ADDR_W-1:0]               wr_addr_min;
    logic [ADDR_W-1:0]               rd_addr_min;
    logic [BURST_W-1:0]              wr_burst_len;
    logic [BURST_W-1:0]              rd_burst_len;
    logic [ADDR_W-1:0]               app_addr;
    logic                            app_en;
    ddr_cmd_e                        app_cmd;
    logic                            app_wdf_wren;
    logic                            app_wdf_end;
    logic [CHAN_NUM-1:0]             wfifo_rden;
    logic [CHAN_NUM-1:0]             rfifo_wren;
    logic [CHAN_NUM-1:0][DATA_W-1:0] rfifo_wdata;

    logic [31:0]       stim_mem [0:NSC*NF-1];
    int                seed = 22;
    int                err_cnt = 0;
    int                chk_cnt = 0;
    int                cyc = 0;
    int                due_q[$];                                  // responder schedule
    logic [ADDR_W-1:0] echo_q[$];
    logic              prev_valid = 1'b0;
    logic [DATA_W-1:0] prev_data = '0;
    int                route_exp = 0;                             // channel owning the beats
    int                beats_seen = 0;

    clk_gen clk_gen_i (.*);

    ddr_frame_top dut_i (.*);

    task automatic check(input logic [DATA_W-1:0] got, input logic [DATA_W-1:0] exp,
                         input string what);
        chk_cnt++;
        if (got !== exp) begin
            err_cnt++;
            $display("ERR at %0d ns: %s is %0h, expected %0h", $time, what, got, exp);
        end
    endtask

    task automatic set_idle_levels();
        for (int c = 0; c < CHAN_NUM; c++) begin
            levels.wfifo_rcount[c] = '0;
            levels.rfifo_wcount[c] = FIFO_CNT_W'(100);            // read fifo well filled
        end
    endtask

    // no command may be issued in these cycles
    task automatic idle_cycles(input int n);
        repeat (n) begin
            @(posedge ui_clk);
            @(negedge ui_clk);
            check(app_en, 1'b0, "app_en while idle");
            check(app_wdf_wren, 1'b0, "app_wdf_wren while idle");
            check(app_wdf_end, 1'b0, "app_wdf_end while idle");
            check(wfifo_rden, '0, "wfifo_rden while idle");
        end
    endtask

    // bit 0..1 wr_load, bit 2 rd_load
    task automatic pulse_loads(input logic [CHAN_NUM:0] mask);
        @(posedge ui_clk);
        #1;
        wr_load = mask[CHAN_NUM-1:0];
        rd_load = mask[CHAN_NUM];
        idle_cycles(3);
        @(posedge ui_clk);
        #1;
        wr_load = '0;
        rd_load = 1'b0;
        idle_cycles(5);                                           // page and rewind settle
    endtask

    task automatic run_burst(input int sc);
        int                base;
        int                chan;
        int                blen;
        int                cnt;
        int                stall_left;
        logic              dir;
        logic [ADDR_W-1:0] exp_addr;
        base       = sc * NF;
        chan       = stim_mem[base + 8];
        dir        = stim_mem[base + 9][0];
        exp_addr   = stim_mem[base + 10][ADDR_W-1:0];
        blen       = dir ? stim_mem[base + 7] : stim_mem[base + 6];
        cnt        = 0;
        stall_left = 0;
        if (dir) begin
            route_exp  = chan;
            beats_seen = 0;
        end
        @(posedge ui_clk);
        #1;
        for (int c = 0; c < CHAN_NUM; c++) begin
            levels.wfifo_rcount[c] = stim_mem[base + c][FIFO_CNT_W-1:0];
            levels.rfifo_wcount[c] = stim_mem[base + 2 + c][FIFO_CNT_W-1:0];
        end
        wr_burst_len = stim_mem[base + 6][BURST_W-1:0];
        rd_burst_len = stim_mem[base + 7][BURST_W-1:0];
        while (cnt < blen) begin
            @(negedge ui_clk);
            if (app_en) begin
                check(app_addr, exp_addr + ADDR_W'(ADDR_STEP * cnt), "app_addr");
                check(app_cmd, dir ? CMD_READ : CMD_WRITE, "app_cmd");
                check(app_wdf_wren, !dir, "app_wdf_wren");
                check(app_wdf_end, !dir, "app_wdf_end");
                check(wfifo_rden, dir ? 0 : (1 << chan), "wfifo_rden");
                if (cnt == 0) begin
                    stall_left = ($random(seed) & 32'h7fff_ffff) % (stim_mem[base + 5] + 1);
                end
                cnt++;
            end else begin
                check(app_wdf_wren, 1'b0, "app_wdf_wren without app_en");
                check(app_wdf_end, 1'b0, "app_wdf_end without app_en");
                check(wfifo_rden, '0, "wfifo_rden without app_en");
            end
            @(posedge ui_clk);
            #1;
            if (cnt > 0) begin
                set_idle_levels();                                // one burst only
            end
            app_rdy = (stall_left == 0);
            if (stall_left > 0) begin
                stall_left--;
            end
        end
        if (dir) begin
            while (beats_seen < blen) @(posedge ui_clk);
        end
    endtask

    // controller model, one beat per accepted read
    always @(negedge ui_clk) begin
        if (rst_n && app_en && (app_cmd == CMD_READ)) begin
            due_q.push_back(cyc + RD_LAT);
            echo_q.push_back(app_addr);
        end
    end

    always @(posedge ui_clk) begin
        cyc = cyc + 1;
        #1;
        app_rd_data_valid = 1'b0;
        app_rd_data       = '0;
        if ((due_q.size() > 0) && (due_q[0] == cyc)) begin
            app_rd_data_valid = 1'b1;
            app_rd_data       = DATA_W'(echo_q.pop_front());      // data echoes the address
            void'(due_q.pop_front());
        end
    end

    // beats show up one cycle later on the routed channel only
    always @(negedge ui_clk) begin
        for (int c = 0; c < CHAN_NUM; c++) begin
            check(rfifo_wren[c], prev_valid && (c == route_exp),
                  $sformatf("rfifo_wren[%0d]", c));
        end
        if (prev_valid) begin
            check(rfifo_wdata[route_exp], prev_data, "rfifo_wdata");
            beats_seen++;
        end
        prev_valid = app_rd_data_valid;
        prev_data  = app_rd_data;
    end

    initial begin
        repeat (LIMIT_CYC) @(posedge ui_clk);
        $display("timeout: the run did not finish within %0d clock cycles", LIMIT_CYC);
        $display("Errors found");
        $finish;
    end

    initial begin
        init_calib_complete = 1'b0;
        app_rdy             = 1'b1;
        app_wdf_rdy         = 1'b1;
        wr_load             = '0;
        rd_load             = 1'b0;
        wr_addr_min         = 28'h0000100;
        rd_addr_min         = 28'h0000040;
        wr_burst_len        = 8'd8;
        rd_burst_len        = 8'd8;
        set_idle_levels();
        levels.wfifo_rcount[0] = '1;                              // would win once calibrated
        levels.rfifo_wcount[1] = '0;
        $readmemh("bench/stim_input.txt", stim_mem);
        if ($isunknown(stim_mem[6]) || (stim_mem[6] == '0)) begin
            $display("stimulus file bench/stim_input.txt is missing or empty");
            $display("Errors found");
            $finish;
        end
        wait (rst_n);
        idle_cycles(10);
        @(posedge ui_clk);
        #1;
        set_idle_levels();
        init_calib_complete = 1'b1;
        idle_cycles(2);
        for (int sc = 0; sc < NSC; sc++) begin
            pulse_loads(stim_mem[sc * NF + 4][CHAN_NUM:0]);
            run_burst(sc);
        end
        idle_cycles(4);
        $display("%0d checks, %0d errors", chk_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

endmodule

//--- bench/clk_gen.sv
`timescale 1ns/100ps

module clk_gen (
    output logic ui_clk,
    output logic rst_n
);

    localparam int RST_CYCLES = 4;

    initial begin
        ui_clk = 1'b0;
        forever #5 ui_clk = ~ui_clk;                              // 10 ns period
    end

    initial begin
        rst_n = 1'b0;
        repeat (RST_CYCLES) @(posedge ui_clk);
        #1 rst_n = 1'b1;                                          // release off the edge
    end

endmodule

//--- design/ddr_frame_top.sv
`timescale 1ns/100ps

module ddr_frame_top
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
(
    input  logic                             ui_clk,
    input  logic                             rst_n,
    input  logic                             init_calib_complete,
    input  logic                             app_rdy,
    input  logic                             app_wdf_rdy,
    input  logic                             app_rd_data_valid,
    input  logic [DATA_W-1:0]                app_rd_data,
    input  fifo_level_t                      levels,
    input  logic [CHAN_NUM-1:0]              wr_load,
    input  logic                             rd_load,
    input  logic [ADDR_W-1:0]                wr_addr_min,
    input  logic [ADDR_W-1:0]                rd_addr_min,
    input  logic [BURST_W-1:0]               wr_burst_len,
    input  logic [BURST_W-1:0]               rd_burst_len,
    output logic [ADDR_W-1:0]                app_addr,
    output logic                             app_en,
    output ddr_cmd_e                         app_cmd,
    output logic                             app_wdf_wren,
    output logic                             app_wdf_end,
    output logic [CHAN_NUM-1:0]              wfifo_rden,
    output logic [CHAN_NUM-1:0]              rfifo_wren,
    output logic [CHAN_NUM-1:0][DATA_W-1:0]  rfifo_wdata
);

    frame_evt_t evt;
    grant_t     grant;
    logic       rd_burst_done;                                    // read burst fully returned

    frame_sync frame_sync_i (
        .ui_clk  (ui_clk),
        .rst_n   (rst_n),
        .wr_load (wr_load),
        .rd_load (rd_load),
        .evt     (evt)
    );

    addr_gen addr_gen_i (
        .ui_clk      (ui_clk),
        .rst_n       (rst_n),
        .evt         (evt),
        .grant       (grant),
        .wr_addr_min (wr_addr_min),
        .rd_addr_min (rd_addr_min),
        .app_addr    (app_addr)
    );

    burst_arbiter burst_arbiter_i (
        .ui_clk              (ui_clk),
        .rst_n               (rst_n),
        .init_calib_complete (init_calib_complete),
        .app_rdy             (app_rdy),
        .app_wdf_rdy         (app_wdf_rdy),
        .levels              (levels),
        .wr_burst_len        (wr_burst_len),
        .rd_burst_len        (rd_burst_len),
        .rd_burst_done       (rd_burst_done),
        .grant               (grant),
        .app_en              (app_en),
        .app_cmd             (app_cmd),
        .app_wdf_wren        (app_wdf_wren),
        .app_wdf_end         (app_wdf_end),
        .wfifo_rden          (wfifo_rden)
    );

    rd_data_router rd_data_router_i (
        .ui_clk            (ui_clk),
        .rst_n             (rst_n),
        .evt               (evt),
        .grant             (grant),
        .rd_burst_len      (rd_burst_len),
        .app_rd_data_valid (app_rd_data_valid),
        .app_rd_data       (app_rd_data),
        .rfifo_wren        (rfifo_wren),
        .rfifo_wdata       (rfifo_wdata),
        .rd_burst_done     (rd_burst_done)
    );

endmodule

//--- design/rd_data_router.sv
`timescale 1ns/100ps

module rd_data_router
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
(
    input  logic                             ui_clk,
    input  logic                             rst_n,
    input  frame_evt_t                       evt,
    input  grant_t                           grant,
    input  logic [BURST_W-1:0]               rd_burst_len,
    input  logic                             app_rd_data_valid,
    input  logic [DATA_W-1:0]                app_rd_data,
    output logic [CHAN_NUM-1:0]              rfifo_wren,
    output logic [CHAN_NUM-1:0][DATA_W-1:0]  rfifo_wdata,
    output logic                             rd_burst_done
);

    logic               rd_phase_q;
    logic               phase_start;
    logic               route_en;                                 // routing target valid
    logic [CH_W-1:0]    route_chan;
    logic [BURST_W-1:0] beat_cnt;

    assign phase_start = grant.active && grant.is_read && !rd_phase_q;

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_phase_q    <= 1'b0;
            route_en      <= 1'b0;
            route_chan    <= '0;
            beat_cnt      <= '0;
            rd_burst_done <= 1'b0;
            rfifo_wren    <= '0;
        end else begin
            rd_phase_q    <= grant.active && grant.is_read;
            rd_burst_done <= 1'b0;

            if (evt.rd_start) begin
                route_en <= 1'b0;                                 // drop stale frame data
            end else if (phase_start) begin
                route_en   <= 1'b1;
                route_chan <= grant.chan;
            end

            if (phase_start) begin
                beat_cnt <= '0;
            end else if (app_rd_data_valid) begin
                if (beat_cnt == rd_burst_len - 1'b1) begin
                    beat_cnt      <= '0;
                    rd_burst_done <= 1'b1;                        // last beat of the burst
                end else begin
                    beat_cnt <= beat_cnt + 1'b1;
                end
            end

            for (int c = 0; c < CHAN_NUM; c++) begin
                rfifo_wren[c] <= route_en && app_rd_data_valid && (route_chan == CH_W'(c));
            end
        end
    end

    // other channels see zeros
    always_ff @(posedge ui_clk) begin
        for (int c = 0; c < CHAN_NUM; c++) begin
            rfifo_wdata[c] <= (route_en && (route_chan == CH_W'(c))) ? app_rd_data : '0;
        end
    end

endmodule

//--- design/burst_arbiter.sv
`timescale 1ns/100ps

module burst_arbiter
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
(
    input  logic                ui_clk,
    input  logic                rst_n,
    input  logic                init_calib_complete,
    input  logic                app_rdy,
    input  logic                app_wdf_rdy,
    input  fifo_level_t         levels,
    input  logic [BURST_W-1:0]  wr_burst_len,
    input  logic [BURST_W-1:0]  rd_burst_len,
    input  logic                rd_burst_done,
    output grant_t              grant,
    output logic                app_en,
    output ddr_cmd_e            app_cmd,
    output logic                app_wdf_wren,
    output logic                app_wdf_end,
    output logic [CHAN_NUM-1:0] wfifo_rden
);

    arb_state_e          state;
    logic [CH_W-1:0]     chan_q;                                  // channel of current phase
    logic [BURST_W-1:0]  burst_cnt;                               // accepted commands
    logic [CHAN_NUM-1:0] wr_want;
    logic [CHAN_NUM-1:0] rd_want;
    logic                pick_valid;
    logic                pick_read;
    logic [CH_W-1:0]     pick_chan;
    logic                in_phase;
    logic                accept;
    logic                last_cmd;

    // who needs service
    always_comb begin
        for (int c = 0; c < CHAN_NUM; c++) begin
            wr_want[c] = (int'(levels.wfifo_rcount[c]) + WR_SLACK) >= int'(wr_burst_len);
            rd_want[c] = int'(levels.rfifo_wcount[c]) < RD_LOW_MARK;
        end
    end

    // writes first, then lowest channel
    always_comb begin
        pick_valid = (|wr_want) || (|rd_want);
        pick_read  = ~(|wr_want);
        pick_chan  = '0;
        for (int c = CHAN_NUM - 1; c >= 0; c--) begin
            if (pick_read ? rd_want[c] : wr_want[c]) begin
                pick_chan = CH_W'(c);
            end
        end
    end

    assign in_phase = (state == ST_WRITE) || (state == ST_READ);
    assign accept   = app_rdy && ((state == ST_READ) || app_wdf_rdy);
    assign last_cmd = burst_cnt == (((state == ST_READ) ? rd_burst_len : wr_burst_len) - 1'b1);

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            chan_q    <= '0;
            burst_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (init_calib_complete) begin
                        state <= ST_READY;
                    end
                end
                ST_READY: begin
                    if (pick_valid) begin
                        state     <= pick_read ? ST_READ : ST_WRITE;
                        chan_q    <= pick_chan;
                        burst_cnt <= '0;
                    end
                end
                ST_WRITE, ST_READ: begin
                    if (app_en) begin
                        burst_cnt <= burst_cnt + 1'b1;
                        if (last_cmd) begin
                            state <= (state == ST_READ) ? ST_READ_WAIT : ST_READY;
                        end
                    end
                end
                ST_READ_WAIT: begin
                    if (rd_burst_done) begin
                        state <= ST_READY;                        // all beats are back
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign app_en       = in_phase && accept;
    assign app_wdf_wren = app_en && (state == ST_WRITE);
    assign app_wdf_end  = app_wdf_wren;                           // one beat per burst at 4:1
    assign app_cmd      = (state == ST_READ) ? CMD_READ : CMD_WRITE;

    always_comb begin
        for (int c = 0; c < CHAN_NUM; c++) begin
            wfifo_rden[c] = app_wdf_wren && (chan_q == CH_W'(c));
        end
        grant.active  = in_phase;
        grant.is_read = (state == ST_READ) || (state == ST_READ_WAIT);
        grant.chan    = chan_q;
        grant.step    = app_en;
    end

endmodule

//--- design/addr_gen.sv
`timescale 1ns/100ps

module addr_gen
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
(
    input  logic              ui_clk,
    input  logic              rst_n,
    input  frame_evt_t        evt,
    input  grant_t            grant,
    input  logic [ADDR_W-1:0] wr_addr_min,
    input  logic [ADDR_W-1:0] rd_addr_min,
    output logic [ADDR_W-1:0] app_addr
);

    logic [CHAN_NUM-1:0][ADDR_W-1:0] wr_ofs;
    logic [CHAN_NUM-1:0][ADDR_W-1:0] rd_ofs;
    logic                            rd_phase;
    logic                            rd_phase_q;
    logic                            rd_rewind;                   // read rewind pending
    logic                            sel_page;
    logic [OFS_W-1:0]                sel_ofs;

    assign rd_phase = grant.active && grant.is_read;

    // a read frame start waits until the arbiter is between phases
    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            rd_phase_q <= 1'b0;
            rd_rewind  <= 1'b0;
        end else begin
            rd_phase_q <= rd_phase;
            if (evt.rd_start) begin
                rd_rewind <= 1'b1;
            end else if (rd_phase && !rd_phase_q) begin
                rd_rewind <= 1'b0;                                // new read phase took it
            end
        end
    end

    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ofs <= '0;
            rd_ofs <= '0;
        end else begin
            for (int c = 0; c < CHAN_NUM; c++) begin
                if (grant.active && !grant.is_read && (grant.chan == CH_W'(c))) begin
                    if (grant.step) begin
                        wr_ofs[c] <= wr_ofs[c] + ADDR_W'(ADDR_STEP);
                    end
                end else if (evt.wr_start[c]) begin
                    wr_ofs[c] <= wr_addr_min;                     // new input frame
                end

                if (grant.active) begin
                    if (grant.step && grant.is_read && (grant.chan == CH_W'(c))) begin
                        rd_ofs[c] <= rd_ofs[c] + ADDR_W'(ADDR_STEP);
                    end
                end else if (rd_rewind) begin
                    rd_ofs[c] <= rd_addr_min;                     // all readers restart
                end
            end
        end
    end

    // {0, chan, page, 0, offset}
    always_comb begin
        sel_page = grant.is_read ? evt.rd_page[grant.chan] : evt.wr_page[grant.chan];
        sel_ofs  = grant.is_read ? rd_ofs[grant.chan][OFS_W-1:0]
                                 : wr_ofs[grant.chan][OFS_W-1:0];
        app_addr                 = '0;
        app_addr[CH_BIT +: CH_W] = grant.chan;
        app_addr[PAGE_BIT]       = sel_page;
        app_addr[OFS_W-1:0]      = sel_ofs;
    end

endmodule

//--- design/frame_sync.sv
`timescale 1ns/100ps

module frame_sync
    import ddr_cfg_pkg::*;
    import ddr_ui_pkg::*;
(
    input  logic                ui_clk,
    input  logic                rst_n,
    input  logic [CHAN_NUM-1:0] wr_load,
    input  logic                rd_load,
    output frame_evt_t          evt
);

    logic [CHAN_NUM:0]   load_s0;                                 // rd_load sits at the msb
    logic [CHAN_NUM:0]   load_s1;
    logic [CHAN_NUM:0]   load_s2;                                 // previous synced level
    logic [CHAN_NUM:0]   start_q;                                 // rising-edge pulses
    logic [CHAN_NUM-1:0] wr_page_q;
    logic [CHAN_NUM-1:0] rd_page_q;

    // two-flop sync then registered edge detect
    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            load_s0 <= '0;
            load_s1 <= '0;
            load_s2 <= '0;
            start_q <= '0;
        end else begin
            load_s0 <= {rd_load, wr_load};
            load_s1 <= load_s0;
            load_s2 <= load_s1;
            start_q <= load_s1 & ~load_s2;
        end
    end

    // write page flips every input frame, read page follows the other one
    always_ff @(posedge ui_clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_page_q <= '1;
            rd_page_q <= '0;
        end else begin
            wr_page_q <= wr_page_q ^ start_q[CHAN_NUM-1:0];
            if (start_q[CHAN_NUM]) begin
                rd_page_q <= ~wr_page_q;                          // read the finished page
            end
        end
    end

    always_comb begin
        evt.wr_start = start_q[CHAN_NUM-1:0];
        evt.rd_start = start_q[CHAN_NUM];
        evt.wr_page  = wr_page_q;
        evt.rd_page  = rd_page_q;
    end

endmodule

//--- design/ddr_ui_pkg.sv
package ddr_ui_pkg;

    import ddr_cfg_pkg::*;

    // arbiter states
    typedef enum logic [2:0] {
        ST_IDLE      = 3'd0,                                      // waiting for calibration
        ST_READY     = 3'd1,                                      // picking next burst
        ST_WRITE     = 3'd2,
        ST_READ      = 3'd3,
        ST_READ_WAIT = 3'd4                                       // read data still in flight
    } arb_state_e;

    // controller command codes
    typedef enum logic [2:0] {
        CMD_WRITE = 3'd0,
        CMD_READ  = 3'd1
    } ddr_cmd_e;

    // current arbiter grant
    typedef struct packed {
        logic            active;                                  // command phase live
        logic            is_read;                                 // direction of the phase
        logic [CH_W-1:0] chan;                                    // granted channel
        logic            step;                                    // command accepted this cycle
    } grant_t;

    // frame events and ping-pong pages
    typedef struct packed {
        logic [CHAN_NUM-1:0] wr_start;                            // one-cycle pulses
        logic                rd_start;
        logic [CHAN_NUM-1:0] wr_page;
        logic [CHAN_NUM-1:0] rd_page;
    } frame_evt_t;

    // external fifo fill levels
    typedef struct packed {
        logic [CHAN_NUM-1:0][FIFO_CNT_W-1:0] wfifo_rcount;        // words waiting to be written
        logic [CHAN_NUM-1:0][FIFO_CNT_W-1:0] rfifo_wcount;        // words waiting to be shown
    } fifo_level_t;

endpackage

//--- design/ddr_cfg_pkg.sv
package ddr_cfg_pkg;

    // channel count and index width
    localparam int CHAN_NUM = 2;                                  // frame channels
    localparam int CH_W     = (CHAN_NUM > 1) ? $clog2(CHAN_NUM) : 1;

    // controller user interface widths
    localparam int ADDR_W     = 28;                               // app_addr width
    localparam int OFS_W      = 22;                               // in-page offset width
    localparam int DATA_W     = 128;                              // one ui data beat
    localparam int FIFO_CNT_W = 11;                               // external fifo fill count
    localparam int BURST_W    = 8;                                // burst length and counters

    // one command moves 8 words at 4:1 ratio, BL8
    localparam int ADDR_STEP = 8;

    // request thresholds
    localparam int RD_LOW_MARK = 5;                               // read fifo nearly empty
    localparam int WR_SLACK    = 2;                               // write fifo almost a burst

    // address map layout
    localparam int CH_BIT   = 25;                                 // channel index lsb
    localparam int PAGE_BIT = 24;                                 // ping-pong page bit

endpackage
